/* Makefile */
# Verilator build and run of the writeback testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* axi_lite_master.sv */
module axi_lite_master (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              write,
	input  wb_pkg::axi_addr_t addr,
	input  wb_pkg::axi_w_t    w_payload,
	output logic              done,
	output wb_pkg::axi_resp_t resp,
	output wb_pkg::xlen_t     rdata,
	output logic              arvalid,
	output wb_pkg::axi_ar_t   ar,
	input  logic              arready,
	input  logic              rvalid,
	input  wb_pkg::axi_r_t    r,
	output logic              rready,
	output logic              awvalid,
	output wb_pkg::axi_aw_t   aw,
	input  logic              awready,
	output logic              wvalid,
	output wb_pkg::axi_w_t    w,
	input  logic              wready,
	input  logic              bvalid,
	input  wb_pkg::axi_b_t    b,
	output logic              bready
);

	wb_pkg::mst_state_e state;

	// request payload, held stable while valid is up
	wb_pkg::axi_addr_t addr_q;
	wb_pkg::axi_w_t    w_q;
	// response capture
	wb_pkg::xlen_t     rdata_q;
	wb_pkg::axi_resp_t resp_q;
	logic              done_q;

	// aw and w finish on their own handshakes
	logic aw_seen;
	logic w_seen;
	logic aw_ok;
	logic w_ok;

	assign arvalid = (state == wb_pkg::READ_ADDR);
	assign rready  = (state == wb_pkg::READ_DATA);
	assign awvalid = (state == wb_pkg::WRITE_REQ) && !aw_seen;
	assign wvalid  = (state == wb_pkg::WRITE_REQ) && !w_seen;
	assign bready  = (state == wb_pkg::WRITE_RESP);

	assign ar.addr = addr_q;
	assign aw.addr = addr_q;
	assign w       = w_q;

	// done or pending this cycle
	assign aw_ok = aw_seen || (awvalid && awready);
	assign w_ok  = w_seen || (wvalid && wready);

	assign done  = done_q;
	assign resp  = resp_q;
	assign rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= wb_pkg::IDLE;
			aw_seen <= 1'b0;
			w_seen  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			// one cycle pulse
			done_q <= 1'b0;
			case (state)
				wb_pkg::IDLE: begin
					aw_seen <= 1'b0;
					w_seen  <= 1'b0;
					if (start) begin
						state <= write ? wb_pkg::WRITE_REQ : wb_pkg::READ_ADDR;
					end
				end
				wb_pkg::READ_ADDR: begin
					if (arready) begin
						state <= wb_pkg::READ_DATA;
					end
				end
				wb_pkg::READ_DATA: begin
					if (rvalid) begin
						done_q <= 1'b1;
						state  <= wb_pkg::IDLE;
					end
				end
				wb_pkg::WRITE_REQ: begin
					aw_seen <= aw_ok;
					w_seen  <= w_ok;
					// wait for b only once both halves went out
					if (aw_ok && w_ok) begin
						state <= wb_pkg::WRITE_RESP;
					end
				end
				wb_pkg::WRITE_RESP: begin
					if (bvalid) begin
						done_q <= 1'b1;
						state  <= wb_pkg::IDLE;
					end
				end
				default: begin
					state <= wb_pkg::IDLE;
				end
			endcase
		end
	end

	// payload latch at start, response latch at handshake
	always_ff @(posedge clk) begin
		if (state == wb_pkg::IDLE && start) begin
			addr_q <= addr;
			w_q    <= w_payload;
		end
		if (rvalid && rready) begin
			rdata_q <= r.data;
			resp_q  <= r.resp;
		end
		if (bvalid && bready) begin
			resp_q <= b.resp;
		end
	end

endmodule

/* files.f */
+incdir+.
wb_pkg.sv
store_lane_gen.sv
load_lane_extract.sv
axi_lite_master.sv
gpr_file.sv
wb_stage.sv
wb_top.sv
tb_axi_mem.sv
tb_wb_top.sv

/* gpr_file.sv */
`include "wb_defs.svh"

module gpr_file (
	input  logic            clk,
	input  logic            rst,
	input  logic            wen,
	input  wb_pkg::reg_id_t wid,
	input  wb_pkg::xlen_t   wdata,
	input  wb_pkg::reg_id_t rs_id,
	output wb_pkg::xlen_t   rs_data
);

	localparam int NUM_REGS = 1 << `WB_REG_ID_W;

	wb_pkg::xlen_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wid != '0) begin
			// x0 never written, stays at its reset zero
			regs[wid] <= wdata;
		end
	end

	// combinational read, no bypass of a same-cycle write
	assign rs_data = regs[rs_id];

endmodule

/* load_lane_extract.sv */
`include "wb_defs.svh"

module load_lane_extract (
	input  logic [2:0]           addr_low,
	input  wb_pkg::access_size_t size,
	input  logic                 is_unsigned,
	input  wb_pkg::xlen_t        rdata,
	output wb_pkg::xlen_t        value
);

	// addressed byte moved down to lane zero
	wb_pkg::xlen_t lane;
	// fill bit for the upper part
	logic          fill;

	assign lane = rdata >> {addr_low, 3'b000};

	always_comb begin
		case (size)
			`WB_SIZE_B: fill = lane[7];
			`WB_SIZE_H: fill = lane[15];
			`WB_SIZE_W: fill = lane[31];
			default:    fill = lane[63];
		endcase
		// lbu, lhu, lwu
		if (is_unsigned) begin
			fill = 1'b0;
		end
	end

	always_comb begin
		case (size)
			`WB_SIZE_B: begin
				value = {{56{fill}}, lane[7:0]};
			end
			`WB_SIZE_H: begin
				value = {{48{fill}}, lane[15:0]};
			end
			`WB_SIZE_W: begin
				value = {{32{fill}}, lane[31:0]};
			end
			default: begin
				// ld, nothing to extend
				value = lane;
			end
		endcase
	end

endmodule

/* store_lane_gen.sv */
`include "wb_defs.svh"

module store_lane_gen (
	input  logic [2:0]           addr_low,
	input  wb_pkg::access_size_t size,
	input  wb_pkg::xlen_t        data,
	output wb_pkg::xlen_t        wdata,
	output wb_pkg::strb_t        strb
);

	// byte mask for the access size, still at lane zero
	wb_pkg::strb_t size_mask;
	// store data with bytes above the size cleared
	wb_pkg::xlen_t data_trim;

	always_comb begin
		case (size)
			`WB_SIZE_B: size_mask = 8'h01;
			`WB_SIZE_H: size_mask = 8'h03;
			`WB_SIZE_W: size_mask = 8'h0f;
			default:    size_mask = 8'hff;
		endcase
	end

	// expand byte mask to a bit mask
	always_comb begin
		for (int i = 0; i < `WB_STRB_W; i++) begin
			data_trim[i*8 +: 8] = size_mask[i] ? data[i*8 +: 8] : 8'h00;
		end
	end

	// aligned access, so the shift never crosses the word
	assign wdata = data_trim << {addr_low, 3'b000};
	assign strb  = size_mask << addr_low;

endmodule

/* tb_axi_mem.sv */
`include "wb_defs.svh"

module tb_axi_mem (
	input  logic              clk,
	input  logic              rst,
	input  logic              arvalid,
	input  wb_pkg::axi_ar_t   ar,
	output logic              arready,
	output logic              rvalid,
	output wb_pkg::axi_r_t    r,
	input  logic              rready,
	input  logic              awvalid,
	input  wb_pkg::axi_aw_t   aw,
	output logic              awready,
	input  logic              wvalid,
	input  wb_pkg::axi_w_t    w,
	output logic              wready,
	output logic              bvalid,
	output wb_pkg::axi_b_t    b,
	input  logic              bready,
	input  wb_pkg::axi_addr_t exp_addr,
	input  wb_pkg::strb_t     exp_strb,
	input  wb_pkg::xlen_t     exp_wdata,
	output logic              fault
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [1:0] RESP_SLVERR = 2'b10;

	wb_pkg::xlen_t mem [256];
	logic [31:0]   delay_seed = 32'd23591;
	logic          fault_q = 1'b0;

	// per channel wait counters
	logic [1:0] ar_cnt;
	logic [1:0] r_cnt;
	logic [1:0] aw_cnt;
	logic [1:0] w_cnt;
	logic [1:0] b_cnt;
	// accepted requests waiting for their response
	logic              rd_pend;
	wb_pkg::axi_addr_t rd_addr;
	logic              aw_got;
	logic              w_got;
	wb_pkg::axi_addr_t wr_addr;
	wb_pkg::axi_w_t    wr_w;
	// set when a valid went unanswered last edge
	logic            ar_hold;
	logic            aw_hold;
	logic            w_hold;
	wb_pkg::axi_ar_t ar_prev;
	wb_pkg::axi_aw_t aw_prev;
	wb_pkg::axi_w_t  w_prev;

	assign fault = fault_q;

	// lcg picks 0 to 3 cycles of ready delay
	function automatic logic [1:0] pick_delay();
		delay_seed = delay_seed * 32'd1103515245 + 32'd12345;
		return delay_seed[17:16];
	endfunction

	// pattern from the byte address of the word
	function automatic wb_pkg::xlen_t fill_word(input int idx);
		logic [31:0] a;
		a = 32'(idx) << 3;
		return {a ^ 32'h5a5a_0000, ~a};
	endfunction

	function automatic wb_pkg::xlen_t lane_bits(input wb_pkg::strb_t s);
		wb_pkg::xlen_t m;
		for (int i = 0; i < 8; i++) begin
			m[i*8 +: 8] = s[i] ? 8'hff : 8'h00;
		end
		return m;
	endfunction

	task automatic note_mismatch(input string name, input wb_pkg::xlen_t got,
			input wb_pkg::xlen_t exp);
		$display("MISMATCH %s got %h expected %h", name, got, exp);
		fault_q = 1'b1;
	endtask

	task automatic note_failure(input string msg);
		$display("memory model: %s", msg);
		fault_q = 1'b1;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			r       <= '0;
			b       <= '0;
			rd_pend <= 1'b0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			ar_hold <= 1'b0;
			aw_hold <= 1'b0;
			w_hold  <= 1'b0;
			ar_cnt  <= pick_delay();
			r_cnt   <= pick_delay();
			aw_cnt  <= pick_delay();
			w_cnt   <= pick_delay();
			b_cnt   <= pick_delay();
			for (int i = 0; i < 256; i++) begin
				mem[i] <= fill_word(i);
			end
		end else begin
			// master valids hold with their payload until ready
			if (ar_hold) begin
				assert (arvalid) else note_failure("arvalid dropped before arready");
				assert (ar == ar_prev) else note_mismatch("ar.addr", 64'(ar.addr),
					64'(ar_prev.addr));
			end
			if (aw_hold) begin
				assert (awvalid) else note_failure("awvalid dropped before awready");
				assert (aw == aw_prev) else note_mismatch("aw.addr", 64'(aw.addr),
					64'(aw_prev.addr));
			end
			if (w_hold) begin
				assert (wvalid) else note_failure("wvalid dropped before wready");
				assert (w == w_prev) else note_mismatch("w.data", w.data, w_prev.data);
			end
			ar_hold <= arvalid && !arready;
			aw_hold <= awvalid && !awready;
			w_hold  <= wvalid && !wready;
			ar_prev <= ar;
			aw_prev <= aw;
			w_prev  <= w;

			// read address
			if (arvalid && arready) begin
				arready <= 1'b0;
				rd_addr <= ar.addr;
				rd_pend <= 1'b1;
				ar_cnt  <= pick_delay();
				assert (ar.addr == exp_addr) else note_mismatch("ar.addr", 64'(ar.addr),
					64'(exp_addr));
			end else if (arvalid && !rd_pend && !rvalid) begin
				if (ar_cnt == 2'd0) arready <= 1'b1;
				else ar_cnt <= ar_cnt - 2'd1;
			end

			// read data with bit 31 as the error region
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if (rd_pend) begin
				if (r_cnt == 2'd0) begin
					rvalid  <= 1'b1;
					rd_pend <= 1'b0;
					r_cnt   <= pick_delay();
					if (rd_addr[31]) begin
						r.data <= 64'hdead_beef_dead_beef;
						r.resp <= RESP_SLVERR;
					end else begin
						r.data <= mem[rd_addr[10:3]];
						r.resp <= `WB_RESP_OKAY;
					end
				end else begin
					r_cnt <= r_cnt - 2'd1;
				end
			end

			// write address and data complete on their own
			if (awvalid && awready) begin
				awready <= 1'b0;
				wr_addr <= aw.addr;
				aw_got  <= 1'b1;
				aw_cnt  <= pick_delay();
				assert (aw.addr == exp_addr) else note_mismatch("aw.addr", 64'(aw.addr),
					64'(exp_addr));
			end else if (awvalid && !aw_got) begin
				if (aw_cnt == 2'd0) awready <= 1'b1;
				else aw_cnt <= aw_cnt - 2'd1;
			end

			if (wvalid && wready) begin
				wready <= 1'b0;
				wr_w   <= w;
				w_got  <= 1'b1;
				w_cnt  <= pick_delay();
				assert (w.strb == exp_strb) else note_mismatch("w.strb", 64'(w.strb),
					64'(exp_strb));
				assert ((w.data & lane_bits(exp_strb)) == (exp_wdata & lane_bits(exp_strb)))
					else note_mismatch("w.data", w.data & lane_bits(exp_strb),
					exp_wdata & lane_bits(exp_strb));
			end else if (wvalid && !w_got) begin
				if (w_cnt == 2'd0) wready <= 1'b1;
				else w_cnt <= w_cnt - 2'd1;
			end

			// write response once both halves arrived
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end else if (aw_got && w_got && !bvalid) begin
				if (b_cnt == 2'd0) begin
					bvalid <= 1'b1;
					aw_got <= 1'b0;
					w_got  <= 1'b0;
					b_cnt  <= pick_delay();
					if (wr_addr[31]) begin
						b.resp <= RESP_SLVERR;
					end else begin
						b.resp <= `WB_RESP_OKAY;
						mem[wr_addr[10:3]] <= (mem[wr_addr[10:3]] & ~lane_bits(wr_w.strb))
							| (wr_w.data & lane_bits(wr_w.strb));
					end
				end else begin
					b_cnt <= b_cnt - 2'd1;
				end
			end
		end
	end

endmodule

/* tb_wb_top.sv */
`include "wb_defs.svh"

module tb_wb_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACCEPT_LIMIT = 20;
	localparam int COMMIT_LIMIT = 40;

	logic              clk = 1'b0;
	logic              rst;
	logic              req_valid;
	wb_pkg::wb_req_t   req;
	logic              req_ready;
	logic              commit_valid;
	wb_pkg::commit_t   commit;
	wb_pkg::reg_id_t   rs_id;
	wb_pkg::xlen_t     rs_data;
	logic              arvalid;
	wb_pkg::axi_ar_t   ar;
	logic              arready;
	logic              rvalid;
	wb_pkg::axi_r_t    r;
	logic              rready;
	logic              awvalid;
	wb_pkg::axi_aw_t   aw;
	logic              awready;
	logic              wvalid;
	wb_pkg::axi_w_t    w;
	logic              wready;
	logic              bvalid;
	wb_pkg::axi_b_t    b;
	logic              bready;
	wb_pkg::axi_addr_t exp_addr;
	wb_pkg::strb_t     exp_strb;
	wb_pkg::xlen_t     exp_wdata;
	logic              mem_fault;

	// reference registers and the 32 word region at 0x100
	wb_pkg::xlen_t ref_regs [32];
	wb_pkg::xlen_t ref_mem [32];
	logic [31:0]   rng_state = 32'd23591;

	always #2 clk = ~clk;

	wb_top uut (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.commit_valid(commit_valid), .commit(commit),
		.rs_id(rs_id), .rs_data(rs_data),
		.arvalid(arvalid), .ar(ar), .arready(arready),
		.rvalid(rvalid), .r(r), .rready(rready),
		.awvalid(awvalid), .aw(aw), .awready(awready),
		.wvalid(wvalid), .w(w), .wready(wready),
		.bvalid(bvalid), .b(b), .bready(bready)
	);

	tb_axi_mem mem_model (
		.clk(clk), .rst(rst),
		.arvalid(arvalid), .ar(ar), .arready(arready),
		.rvalid(rvalid), .r(r), .rready(rready),
		.awvalid(awvalid), .aw(aw), .awready(awready),
		.wvalid(wvalid), .w(w), .wready(wready),
		.bvalid(bvalid), .b(b), .bready(bready),
		.exp_addr(exp_addr),
		.exp_strb(exp_strb), .exp_wdata(exp_wdata), .fault(mem_fault)
	);

	task automatic abort_run(input string msg);
		$display("Test failed");
		$fatal(1, "%s", msg);
	endtask

	always @(posedge mem_fault) abort_run("memory model flagged a bus or data error");

	task automatic expect_word(input string name, input wb_pkg::xlen_t got,
			input wb_pkg::xlen_t exp);
		assert (got === exp) else begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			abort_run("value check failed");
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			abort_run("value check failed");
		end
	endtask

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic wb_pkg::xlen_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi, lo};
	endfunction

	function automatic int size_bytes(input wb_pkg::access_size_t size);
		return 1 << size;
	endfunction

	// bytes covered by the access
	function automatic wb_pkg::strb_t lane_strobe(input wb_pkg::access_size_t size,
			input int off);
		wb_pkg::strb_t s;
		s = '0;
		for (int i = 0; i < 8; i++) begin
			if (i >= off && i < off + size_bytes(size)) s[i] = 1'b1;
		end
		return s;
	endfunction

	// low store bytes laid over a word starting at off
	function automatic wb_pkg::xlen_t place_bytes(input wb_pkg::xlen_t base,
			input wb_pkg::access_size_t size, input int off, input wb_pkg::xlen_t data);
		wb_pkg::xlen_t v;
		v = base;
		for (int j = 0; j < size_bytes(size); j++) begin
			v[(off+j)*8 +: 8] = data[j*8 +: 8];
		end
		return v;
	endfunction

	function automatic wb_pkg::xlen_t extend_lanes(input wb_pkg::access_size_t size,
			input int off, input logic uns, input wb_pkg::xlen_t word);
		wb_pkg::xlen_t v;
		int n;
		n = size_bytes(size);
		v = '0;
		for (int j = 0; j < n; j++) begin
			v[j*8 +: 8] = word[(off+j)*8 +: 8];
		end
		// top selected bit decides the fill
		if (!uns && v[n*8-1]) begin
			for (int k = n * 8; k < 64; k++) v[k] = 1'b1;
		end
		return v;
	endfunction

	// drive one request and wait for its commit pulse
	task automatic issue_op(input wb_pkg::wb_req_t op, output wb_pkg::commit_t got);
		int waited;
		waited = 0;
		@(posedge clk);
		req_valid <= 1'b1;
		req       <= op;
		@(negedge clk);
		while (!req_ready) begin
			waited++;
			if (waited > ACCEPT_LIMIT) abort_run("request was never accepted");
			@(negedge clk);
		end
		expect_bit("commit_valid", commit_valid, 1'b0);
		@(posedge clk);
		req_valid <= 1'b0;
		waited = 0;
		@(negedge clk);
		// alu retires on the very next cycle
		if (op.kind == `WB_OP_ALU) expect_bit("commit_valid", commit_valid, 1'b1);
		while (!commit_valid) begin
			expect_bit("req_ready", req_ready, 1'b0);
			waited++;
			if (waited > COMMIT_LIMIT) abort_run("no commit pulse after the request");
			@(negedge clk);
		end
		if (op.kind != `WB_OP_ALU) expect_bit("req_ready", req_ready, 1'b0);
		got = commit;
		@(negedge clk);
		expect_bit("commit_valid", commit_valid, 1'b0);
		expect_bit("req_ready", req_ready, 1'b1);
	endtask

	task automatic check_commit(input wb_pkg::wb_req_t op, input wb_pkg::commit_t got);
		logic          bad;
		logic          wen;
		int            off;
		int            idx;
		wb_pkg::xlen_t wdata;
		bad   = (op.kind != `WB_OP_ALU) && op.value[31];
		wen   = !bad && (op.kind != `WB_OP_STORE) && (op.rd != '0);
		off   = int'(op.value[2:0]);
		idx   = int'(op.value[7:3]);
		wdata = op.value;
		expect_word("commit.pc", got.pc, op.pc);
		expect_word("commit.rd", 64'(got.rd), 64'(op.rd));
		expect_bit("commit.err", got.err, bad);
		expect_bit("commit.wen", got.wen, wen);
		if (op.kind == `WB_OP_LOAD && !bad) begin
			wdata = extend_lanes(op.size, off, op.is_unsigned, ref_mem[idx]);
		end
		if (op.kind == `WB_OP_ALU || (op.kind == `WB_OP_LOAD && !bad)) begin
			expect_word("commit.wdata", got.wdata, wdata);
		end
		if (wen) ref_regs[op.rd] = wdata;
		if (op.kind == `WB_OP_STORE && !bad) begin
			ref_mem[idx] = place_bytes(ref_mem[idx], op.size, off, op.store_data);
		end
	endtask

	task automatic read_back(input wb_pkg::reg_id_t id);
		@(posedge clk);
		rs_id <= id;
		@(negedge clk);
		expect_word($sformatf("rs_data[x%0d]", id), rs_data, ref_regs[id]);
	endtask

	task automatic run_op(input wb_pkg::op_kind_t kind, input wb_pkg::access_size_t size,
			input logic uns, input wb_pkg::reg_id_t rd, input wb_pkg::xlen_t value,
			input wb_pkg::xlen_t sdata);
		wb_pkg::wb_req_t op;
		wb_pkg::commit_t got;
		op.pc          = rand_word() & ~64'h3;
		op.kind        = kind;
		op.size        = size;
		op.is_unsigned = uns;
		op.rd          = rd;
		op.value       = value;
		op.store_data  = sdata;
		@(posedge clk);
		exp_addr  <= value[`WB_AXI_ADDR_W-1:0];
		exp_strb  <= lane_strobe(size, int'(value[2:0]));
		exp_wdata <= place_bytes('0, size, int'(value[2:0]), sdata);
		issue_op(op, got);
		check_commit(op, got);
		read_back(rd);
		read_back(5'd0);
	endtask

	initial begin
		logic [31:0]          rv;
		wb_pkg::access_size_t size;
		int                   off;
		logic [31:0]          addr;
		rst       <= 1'b1;
		req_valid <= 1'b0;
		req       <= '0;
		rs_id     <= '0;
		exp_addr  <= '0;
		exp_strb  <= '0;
		exp_wdata <= '0;
		for (int i = 0; i < 32; i++) ref_regs[i] = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// idle outputs after reset
		@(negedge clk);
		expect_bit("req_ready", req_ready, 1'b1);
		expect_bit("commit_valid", commit_valid, 1'b0);
		expect_bit("arvalid", arvalid, 1'b0);
		expect_bit("awvalid", awvalid, 1'b0);
		expect_bit("wvalid", wvalid, 1'b0);
		expect_bit("rready", rready, 1'b0);
		expect_bit("bready", bready, 1'b0);
		for (int i = 0; i < 32; i++) read_back(5'(i));

		// alu ops with every eighth aimed at x0
		for (int n = 0; n < 40; n++) begin
			rv = next_rand();
			run_op(`WB_OP_ALU, `WB_SIZE_D, 1'b0, (n % 8 == 0) ? 5'd0 : rv[20:16],
				rand_word(), '0);
		end

		// whole region with doubleword stores first
		for (int n = 0; n < 32; n++) begin
			run_op(`WB_OP_STORE, `WB_SIZE_D, 1'b0, 5'(n), {32'h0, 32'h100 + 32'(n * 8)},
				rand_word());
		end

		// sub-word stores then loads of all kinds
		for (int n = 0; n < 112; n++) begin
			rv   = next_rand();
			size = rv[17:16];
			off  = int'(rv[20:18]) & ~(size_bytes(size) - 1);
			addr = 32'h100 + 32'(int'(rv[25:21]) * 8 + off);
			if (n < 48) run_op(`WB_OP_STORE, size, 1'b0, rv[31:27], {32'h0, addr}, rand_word());
			else run_op(`WB_OP_LOAD, size, rv[26], rv[31:27], {32'h0, addr}, '0);
		end

		// error region accesses and then the aliased word that must survive
		for (int n = 0; n < 10; n++) begin
			rv   = next_rand();
			size = rv[17:16];
			off  = int'(rv[20:18]) & ~(size_bytes(size) - 1);
			addr = 32'h8000_0100 + 32'(int'(rv[25:21]) * 8 + off);
			run_op(`WB_OP_LOAD, size, rv[26], rv[31:27] | 5'd1, {32'h0, addr}, '0);
			run_op(`WB_OP_STORE, size, 1'b0, rv[31:27], {32'h0, addr}, rand_word());
			run_op(`WB_OP_LOAD, `WB_SIZE_D, 1'b0, 5'd9, {32'h0, addr & 32'h7fff_fff8}, '0);
		end

		if (mem_fault) begin
			abort_run("memory model flagged a bus or data error");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

/* wb_defs.svh */
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// datapath and bus widths
`define WB_XLEN       64
`define WB_REG_ID_W   5
`define WB_AXI_ADDR_W 32
`define WB_STRB_W     8

// operation kind, replaces the opcode tables
`define WB_OP_ALU   2'd0
`define WB_OP_LOAD  2'd1
`define WB_OP_STORE 2'd2

// access size, log2 of the byte count
`define WB_SIZE_B 2'd0
`define WB_SIZE_H 2'd1
`define WB_SIZE_W 2'd2
`define WB_SIZE_D 2'd3

`define WB_RESP_OKAY 2'b00

`endif

/* wb_pkg.sv */
`include "wb_defs.svh"

package wb_pkg;

	// plain vectors with a meaning
	typedef logic [`WB_XLEN-1:0]       xlen_t;
	typedef logic [`WB_REG_ID_W-1:0]   reg_id_t;
	typedef logic [`WB_AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [`WB_STRB_W-1:0]     strb_t;
	typedef logic [1:0]                op_kind_t;
	typedef logic [1:0]                access_size_t;
	typedef logic [1:0]                axi_resp_t;

	// one retiring operation from execute
	// value is the alu result, or the address for memory kinds
	typedef struct packed {
		xlen_t        pc;
		op_kind_t     kind;
		access_size_t size;
		logic         is_unsigned;
		reg_id_t      rd;
		xlen_t        value;
		xlen_t        store_data;
	} wb_req_t;

	// retire record, one per finished operation
	typedef struct packed {
		xlen_t   pc;
		reg_id_t rd;
		logic    wen;
		xlen_t   wdata;
		logic    err;
	} commit_t;

	// axi4-lite channel payloads, prot left out
	typedef struct packed {
		axi_addr_t addr;
	} axi_ar_t;

	typedef struct packed {
		axi_addr_t addr;
	} axi_aw_t;

	typedef struct packed {
		xlen_t data;
		strb_t strb;
	} axi_w_t;

	typedef struct packed {
		xlen_t     data;
		axi_resp_t resp;
	} axi_r_t;

	typedef struct packed {
		axi_resp_t resp;
	} axi_b_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_DATA,
		WRITE_REQ,
		WRITE_RESP
	} mst_state_e;

endpackage

/* wb_stage.sv */
`include "wb_defs.svh"

module wb_stage (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  wb_pkg::wb_req_t   req,
	output logic              req_ready,
	output logic              mem_start,
	output logic              mem_write,
	output wb_pkg::axi_addr_t mem_addr,
	input  logic              mem_done,
	input  wb_pkg::axi_resp_t mem_resp,
	input  wb_pkg::xlen_t     load_data,
	output wb_pkg::wb_req_t   held,
	output logic              reg_wen,
	output wb_pkg::reg_id_t   reg_wid,
	output wb_pkg::xlen_t     reg_wdata,
	output logic              commit_valid,
	output wb_pkg::commit_t   commit
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_WAIT
	} stage_state_e;

	stage_state_e    state;
	// WB pipeline register
	wb_pkg::wb_req_t held_q;
	// alu op accepted last cycle, commits now
	logic            alu_pend;

	logic accept;
	logic req_is_mem;
	logic is_load;
	logic is_store;
	logic is_alu;
	logic mem_fin;
	logic resp_ok;

	assign req_ready  = (state == ST_IDLE);
	assign accept     = req_valid && req_ready;
	assign req_is_mem = (req.kind == `WB_OP_LOAD) || (req.kind == `WB_OP_STORE);

	// decode of the held operation
	assign is_load  = (held_q.kind == `WB_OP_LOAD);
	assign is_store = (held_q.kind == `WB_OP_STORE);
	assign is_alu   = !is_load && !is_store;

	// memory request from the held op, one cycle after accept
	assign mem_start = (state == ST_START);
	assign mem_write = is_store;
	assign mem_addr  = held_q.value[`WB_AXI_ADDR_W-1:0];
	assign held      = held_q;

	assign mem_fin = (state == ST_WAIT) && mem_done;
	// alu never faults
	assign resp_ok = is_alu || (mem_resp == `WB_RESP_OKAY);

	assign commit_valid = alu_pend || mem_fin;

	always_comb begin
		commit.pc  = held_q.pc;
		commit.rd  = held_q.rd;
		commit.err = !resp_ok;
		// stores and x0 targets retire without a write
		commit.wen = resp_ok && !is_store && (held_q.rd != '0);
		if (is_alu) begin
			commit.wdata = held_q.value;
		end else if (is_load && resp_ok) begin
			commit.wdata = load_data;
		end else begin
			commit.wdata = '0;
		end
	end

	// register write rides on the commit pulse
	assign reg_wen   = commit_valid && commit.wen;
	assign reg_wid   = commit.rd;
	assign reg_wdata = commit.wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_IDLE;
			alu_pend <= 1'b0;
		end else begin
			alu_pend <= accept && !req_is_mem;
			case (state)
				ST_IDLE: begin
					if (accept && req_is_mem) begin
						state <= ST_START;
					end
				end
				ST_START: begin
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (mem_done) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			held_q <= req;
		end
	end

endmodule

/* wb_top.sv */
module wb_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  wb_pkg::wb_req_t   req,
	output logic              req_ready,
	output logic              commit_valid,
	output wb_pkg::commit_t   commit,
	input  wb_pkg::reg_id_t   rs_id,
	output wb_pkg::xlen_t     rs_data,
	output logic              arvalid,
	output wb_pkg::axi_ar_t   ar,
	input  logic              arready,
	input  logic              rvalid,
	input  wb_pkg::axi_r_t    r,
	output logic              rready,
	output logic              awvalid,
	output wb_pkg::axi_aw_t   aw,
	input  logic              awready,
	output logic              wvalid,
	output wb_pkg::axi_w_t    w,
	input  logic              wready,
	input  logic              bvalid,
	input  wb_pkg::axi_b_t    b,
	output logic              bready
);

	// stage to master
	logic              mem_start;
	logic              mem_write;
	wb_pkg::axi_addr_t mem_addr;
	logic              mem_done;
	wb_pkg::axi_resp_t mem_resp;
	wb_pkg::xlen_t     mem_rdata;
	// held op feeds both lane units
	wb_pkg::wb_req_t   held;
	wb_pkg::xlen_t     load_value;
	wire wb_pkg::axi_w_t st_w;
	// register write port
	logic              reg_wen;
	wb_pkg::reg_id_t   reg_wid;
	wb_pkg::xlen_t     reg_wdata;

	wb_stage u_stage (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req          (req),
		.req_ready    (req_ready),
		.mem_start    (mem_start),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_done     (mem_done),
		.mem_resp     (mem_resp),
		.load_data    (load_value),
		.held         (held),
		.reg_wen      (reg_wen),
		.reg_wid      (reg_wid),
		.reg_wdata    (reg_wdata),
		.commit_valid (commit_valid),
		.commit       (commit)
	);

	store_lane_gen u_store (
		.addr_low (held.value[2:0]),
		.size     (held.size),
		.data     (held.store_data),
		.wdata    (st_w.data),
		.strb     (st_w.strb)
	);

	load_lane_extract u_load (
		.addr_low    (held.value[2:0]),
		.size        (held.size),
		.is_unsigned (held.is_unsigned),
		.rdata       (mem_rdata),
		.value       (load_value)
	);

	axi_lite_master u_master (
		.clk       (clk),
		.rst       (rst),
		.start     (mem_start),
		.write     (mem_write),
		.addr      (mem_addr),
		.w_payload (st_w),
		.done      (mem_done),
		.resp      (mem_resp),
		.rdata     (mem_rdata),
		.arvalid   (arvalid),
		.ar        (ar),
		.arready   (arready),
		.rvalid    (rvalid),
		.r         (r),
		.rready    (rready),
		.awvalid   (awvalid),
		.aw        (aw),
		.awready   (awready),
		.wvalid    (wvalid),
		.w         (w),
		.wready    (wready),
		.bvalid    (bvalid),
		.b         (b),
		.bready    (bready)
	);

	gpr_file u_gpr (
		.clk     (clk),
		.rst     (rst),
		.wen     (reg_wen),
		.wid     (reg_wid),
		.wdata   (reg_wdata),
		.rs_id   (rs_id),
		.rs_data (rs_data)
	);

endmodule
